// ==== files.f ====
+incdir+logic
logic/apu_bus_pkg.sv
logic/apu_audio_pkg.sv
logic/apu_control.sv
logic/apu_square_channel.sv
logic/apu_mixer.sv
logic/apu_top.sv
sim/apu_checker.sv
sim/apu_sva.sv
sim/apu_tb.sv

// ==== logic/apu_audio_pkg.sv ====
`include "apu_settings.svh"

package apu_audio_pkg;

	typedef logic [3:0] chan_level_t; // 0..15 per channel

	typedef logic [`APU_NUM_CH-1:0] chan_status_t; // one active flag per channel

	// ff24 and ff25 as seen by the mixer
	typedef struct packed {
		logic [2:0] right_vol;
		logic [2:0] left_vol;
		logic [1:0] vin; // left in bit 1, right in bit 0
		logic [7:0] pan; // right enables 3..0, left enables 7..4
	} mixer_cfg_t;

	typedef struct packed {
		logic [7:0] left;
		logic [7:0] right;
	} stereo_sample_t;

endpackage

// ==== logic/apu_bus_pkg.sv ====
package apu_bus_pkg;

	// cpu side request, low address byte only (high byte ff assumed)
	typedef struct packed {
		logic [7:0] addr;
		logic [7:0] wdata;
		logic       wr; // write strobe
		logic       rd; // read strobe
	} apu_bus_t;

	typedef enum logic [7:0] {
		nr10 = 8'h10, // sweep, not built
		nr11 = 8'h11, // ch1 duty and length
		nr12 = 8'h12, // ch1 volume
		nr13 = 8'h13, // ch1 period low
		nr14 = 8'h14, // ch1 trigger, length enable, period high
		nr21 = 8'h16, // ch2 duty and length
		nr22 = 8'h17,
		nr23 = 8'h18,
		nr24 = 8'h19,
		nr50 = 8'h24, // master volume
		nr51 = 8'h25, // panning
		nr52 = 8'h26 // power and status
	} apu_reg_e;

endpackage

// ==== logic/apu_control.sv ====
`include "apu_settings.svh"

module apu_control
	import apu_bus_pkg::*;
	import apu_audio_pkg::*;
(
	input  logic                          apuv_4mhz,
	input  logic                          rst_n,
	input  logic                          t1_nt2,
	input  logic                          byfe_128hz,
	input  apu_bus_t                      bus,
	input  chan_status_t                  status,
	input  logic [`APU_NUM_CH-1:0][7:0]   ch_rd_data,
	input  logic [`APU_NUM_CH-1:0]        ch_rd_hit,
	output logic [7:0]                    rd_data,
	output logic                          power_n_reset,
	output logic                          en_2mhz,
	output logic                          en_1mhz,
	output logic                          frame_tick,
	output logic                          power_on,
	output mixer_cfg_t                    mixer_cfg
);
	localparam int TICK_W = $clog2(`APU_TEST_TICK_DIV);

	logic [1:0]        div_cnt;
	logic [7:0]        vol_reg; // ff24
	logic [7:0]        pan_reg; // ff25
	logic              test_mode;
	logic [TICK_W-1:0] tick_cnt;
	logic              test_tick;
	logic [2:0]        tick_sync;
	logic              tick_rise;
	logic              wr_vol;
	logic              wr_pan;
	logic              wr_pwr;
	logic [7:0]        ch_byte;
	logic [7:0]        rd_next;

	assign wr_vol = bus.wr && (bus.addr == nr50);
	assign wr_pan = bus.wr && (bus.addr == nr51);
	assign wr_pwr = bus.wr && (bus.addr == nr52);

	// 4 MHz divided down, enables stay low through reset
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 2'd1;
	end

	assign en_2mhz = div_cnt[0];
	assign en_1mhz = en_2mhz && div_cnt[1]; // every second 2 MHz pulse

	// ff26, power bit and test latch; always writable
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			power_on <= 1'b0;
			test_mode <= 1'b0;
		end else if (wr_pwr) begin
			power_on <= bus.wdata[7];
			test_mode <= bus.wdata[4] && t1_nt2; // needs the test pin high
		end
	end

	assign power_n_reset = rst_n && power_on;

	// ff24 and ff25, cleared one edge after power goes off
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			vol_reg <= '0;
			pan_reg <= '0;
		end else if (!power_on) begin
			vol_reg <= '0;
			pan_reg <= '0;
		end else begin
			if (wr_vol)
				vol_reg <= bus.wdata;
			if (wr_pan)
				pan_reg <= bus.wdata;
		end
	end

	assign mixer_cfg = '{
		right_vol: vol_reg[2:0],
		left_vol:  vol_reg[6:4],
		vin:       {vol_reg[7], vol_reg[3]},
		pan:       pan_reg
	};

	// fast frame tick for test mode
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n)
			tick_cnt <= '0;
		else if (!test_mode)
			tick_cnt <= '0;
		else if (test_tick)
			tick_cnt <= '0;
		else if (en_1mhz)
			tick_cnt <= tick_cnt + 1'b1;
	end

	assign test_tick = en_1mhz && (tick_cnt == TICK_W'(`APU_TEST_TICK_DIV - 1));

	// 128 Hz tick comes from another clock domain
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n)
			tick_sync <= '0;
		else
			tick_sync <= {tick_sync[1:0], byfe_128hz};
	end

	assign tick_rise = tick_sync[1] && !tick_sync[2];
	assign frame_tick = test_mode ? test_tick : tick_rise;

	// channel byte, ff for anything nobody claims
	always_comb begin
		ch_byte = 8'hff;
		for (int i = 0; i < `APU_NUM_CH; i++) begin
			if (ch_rd_hit[i])
				ch_byte = ch_rd_data[i];
		end
	end

	always_comb begin
		case (bus.addr)
			nr50:    rd_next = power_on ? vol_reg : 8'h00;
			nr51:    rd_next = power_on ? pan_reg : 8'h00;
			nr52:    rd_next = {power_on, 3'b111, {(4 - `APU_NUM_CH){1'b0}}, status};
			default: rd_next = ch_byte;
		endcase
	end

	// read data held until the next read strobe
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n)
			rd_data <= '0;
		else if (bus.rd)
			rd_data <= rd_next;
	end

endmodule

// ==== logic/apu_mixer.sv ====
`include "apu_settings.svh"

module apu_mixer
	import apu_audio_pkg::*;
(
	input  logic                          apuv_4mhz,
	input  logic                          rst_n,
	input  logic                          power_on,
	input  chan_level_t [`APU_NUM_CH-1:0] levels,
	input  mixer_cfg_t                    cfg,
	output stereo_sample_t                sample
);
	localparam int SUM_W = $clog2(`APU_NUM_CH * 15 + 1); // 0..30 for two channels

	stereo_sample_t mix;

	// one side of the output, panned levels summed then scaled by vol + 1
	function automatic logic [7:0] mix_side(
		input chan_level_t [`APU_NUM_CH-1:0] lv,
		input logic [3:0]                    en,
		input logic [2:0]                    vol
	);
		logic [SUM_W-1:0] sum;
		sum = '0;
		for (int i = 0; i < `APU_NUM_CH; i++) begin
			if (en[i])
				sum = sum + SUM_W'(lv[i]);
		end
		return 8'(sum) * (8'(vol) + 8'd1); // at most 240
	endfunction

	always_comb begin
		mix.left = mix_side(levels, cfg.pan[7:4], cfg.left_vol);
		mix.right = mix_side(levels, cfg.pan[3:0], cfg.right_vol);
	end

	// one cycle behind the levels
	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n)
			sample <= '0;
		else if (!power_on)
			sample <= '0; // silent while powered down
		else
			sample <= mix;
	end

endmodule

// ==== logic/apu_settings.svh ====
`ifndef APU_SETTINGS_SVH
`define APU_SETTINGS_SVH

// channel count and register layout
`define APU_NUM_CH 2 // square tone channels
`define APU_CH_REGS 4 // registers per tone channel

// field widths
`define APU_LEN_BITS 6 // length field of register 1
`define APU_FREQ_BITS 11 // period field of registers 3 and 4

// 1 MHz enables per frame tick in test mode
`define APU_TEST_TICK_DIV 16

`endif

// ==== logic/apu_square_channel.sv ====
`include "apu_settings.svh"

module apu_square_channel
	import apu_bus_pkg::*;
	import apu_audio_pkg::*;
#(
	parameter apu_reg_e BASE = nr11 // address of register 1
) (
	input  logic        apuv_4mhz,
	input  logic        rst_n,
	input  logic        power_n_reset,
	input  logic        en_1mhz,
	input  logic        frame_tick,
	input  apu_bus_t    bus,
	output chan_level_t level,
	output logic        active,
	output logic [7:0]  rd_byte,
	output logic        rd_hit
);
	localparam int LW = `APU_LEN_BITS;
	localparam int FW = `APU_FREQ_BITS;

	logic [7:0]    offset;
	logic          hit;
	logic          wr_hit;
	logic          trigger;
	logic [1:0]    duty;
	logic [LW-1:0] len_load;
	logic [7:0]    env_reg; // volume in the upper nibble
	logic [FW-1:0] freq;
	logic [FW-1:0] trig_freq;
	logic          len_en;
	logic [LW:0]   len_cnt;
	logic [FW:0]   timer;
	logic [2:0]    step;
	logic [7:0]    pattern;
	logic [7:0]    ro_bits;
	logic [7:0]    wo_mask;

	assign offset = bus.addr - 8'(BASE); // wraps high below base
	assign hit = offset < 8'(`APU_CH_REGS);
	assign wr_hit = bus.wr && hit;
	assign rd_hit = bus.rd && hit;
	assign trigger = wr_hit && (offset[1:0] == 2'd3) && bus.wdata[7];
	assign trig_freq = {bus.wdata[FW-9:0], freq[7:0]}; // period high from the same write

	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			duty <= '0;
			len_load <= '0;
			env_reg <= '0;
			freq <= '0;
			len_en <= 1'b0;
		end else if (!power_n_reset) begin
			duty <= '0;
			len_load <= '0;
			env_reg <= '0;
			freq <= '0;
			len_en <= 1'b0;
		end else if (wr_hit) begin
			case (offset[1:0])
				2'd0: begin
					duty <= bus.wdata[7:6];
					len_load <= bus.wdata[LW-1:0];
				end
				2'd1: env_reg <= bus.wdata;
				2'd2: freq[7:0] <= bus.wdata;
				default: begin
					len_en <= bus.wdata[6];
					freq[FW-1:8] <= bus.wdata[FW-9:0];
				end
			endcase
		end
	end

	always_ff @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			active <= 1'b0;
			len_cnt <= '0;
			timer <= '0;
			step <= '0;
		end else if (!power_n_reset) begin
			active <= 1'b0;
			len_cnt <= '0;
			timer <= '0;
			step <= '0;
		end else if (trigger && (env_reg[7:4] != 4'd0)) begin
			active <= 1'b1;
			len_cnt <= (LW+1)'(1 << LW) - {1'b0, len_load}; // 64 - length
			timer <= (FW+1)'(1 << FW) - {1'b0, trig_freq}; // 2048 - period
			step <= '0;
		end else begin
			if (en_1mhz) begin
				if (timer <= (FW+1)'(1)) begin
					timer <= (FW+1)'(1 << FW) - {1'b0, freq};
					step <= step + 3'd1;
				end else begin
					timer <= timer - 1'b1;
				end
			end
			if (frame_tick && len_en && active && (len_cnt != '0)) begin
				len_cnt <= len_cnt - 1'b1;
				if (len_cnt == (LW+1)'(1))
					active <= 1'b0; // length ran out
			end
		end
	end

	always_comb begin
		case (duty)
			2'd0:    pattern = 8'b0000_0001; // 12.5 %
			2'd1:    pattern = 8'b1000_0001; // 25 %
			2'd2:    pattern = 8'b1000_0111; // 50 %
			default: pattern = 8'b0111_1110; // 75 %
		endcase
	end

	assign level = (active && pattern[step]) ? env_reg[7:4] : '0;

	// write-only fields read back as ones
	always_comb begin
		case (offset[1:0])
			2'd0: begin
				ro_bits = {duty, {LW{1'b0}}};
				wo_mask = {2'b00, {LW{1'b1}}};
			end
			2'd1: begin
				ro_bits = env_reg;
				wo_mask = 8'h00;
			end
			2'd2: begin
				ro_bits = 8'h00;
				wo_mask = 8'hff;
			end
			default: begin
				ro_bits = {1'b0, len_en, 6'h00};
				wo_mask = 8'hbf;
			end
		endcase
	end

	assign rd_byte = (power_n_reset ? ro_bits : 8'h00) | wo_mask; // stored bits hidden when off

endmodule

// ==== logic/apu_top.sv ====
`include "apu_settings.svh"

module apu_top
	import apu_bus_pkg::*;
	import apu_audio_pkg::*;
(
	input  logic           apuv_4mhz,
	input  logic           rst_n,
	input  logic           t1_nt2,
	input  logic           byfe_128hz,
	input  apu_bus_t       bus,
	output logic [7:0]     rd_data,
	output stereo_sample_t sample
);
	logic                          power_n_reset;
	logic                          en_1mhz;
	logic                          frame_tick;
	logic                          power_on;
	mixer_cfg_t                    mixer_cfg;
	chan_level_t [`APU_NUM_CH-1:0] levels;
	chan_status_t                  status;
	logic [`APU_NUM_CH-1:0][7:0]   ch_rd_data;
	logic [`APU_NUM_CH-1:0]        ch_rd_hit;

	apu_control u_control (
		.apuv_4mhz     (apuv_4mhz),
		.rst_n         (rst_n),
		.t1_nt2        (t1_nt2),
		.byfe_128hz    (byfe_128hz),
		.bus           (bus),
		.status        (status),
		.ch_rd_data    (ch_rd_data),
		.ch_rd_hit     (ch_rd_hit),
		.rd_data       (rd_data),
		.power_n_reset (power_n_reset),
		.en_2mhz       (), // only the 1 MHz enable is needed by the channels
		.en_1mhz       (en_1mhz),
		.frame_tick    (frame_tick),
		.power_on      (power_on),
		.mixer_cfg     (mixer_cfg)
	);

	apu_square_channel #(.BASE(nr11)) u_ch1 (
		.apuv_4mhz     (apuv_4mhz),
		.rst_n         (rst_n),
		.power_n_reset (power_n_reset),
		.en_1mhz       (en_1mhz),
		.frame_tick    (frame_tick),
		.bus           (bus),
		.level         (levels[0]),
		.active        (status[0]),
		.rd_byte       (ch_rd_data[0]),
		.rd_hit        (ch_rd_hit[0])
	);

	apu_square_channel #(.BASE(nr21)) u_ch2 (
		.apuv_4mhz     (apuv_4mhz),
		.rst_n         (rst_n),
		.power_n_reset (power_n_reset),
		.en_1mhz       (en_1mhz),
		.frame_tick    (frame_tick),
		.bus           (bus),
		.level         (levels[1]),
		.active        (status[1]),
		.rd_byte       (ch_rd_data[1]),
		.rd_hit        (ch_rd_hit[1])
	);

	apu_mixer u_mixer (
		.apuv_4mhz (apuv_4mhz),
		.rst_n     (rst_n),
		.power_on  (power_on),
		.levels    (levels),
		.cfg       (mixer_cfg),
		.sample    (sample)
	);

endmodule

// ==== sim/apu_checker.sv ====
module apu_checker
	import apu_bus_pkg::*;
	import apu_audio_pkg::*;
(
	input  logic                 apuv_4mhz,
	input  logic                 rst_n,
	input  apu_bus_t             bus,
	input  logic [7:0]           rd_data,
	input  stereo_sample_t       sample,
	input  logic                 m_power,
	input  logic [7:0]           m_vol,
	input  logic [7:0]           m_pan,
	input  logic [1:0][3:0][7:0] m_ch,
	input  chan_status_t         m_active,
	input  logic [1:0]           status_mask,
	input  logic [2:0]           phase,
	output int                   errors
);
	int              err_count = 0;
	logic            rd_pend = 1'b0;
	logic [7:0]      rd_exp;
	logic [7:0]      rd_ign; // bits left out of the compare
	logic [7:0]      rd_addr;
	logic [2:0]      rd_phase;
	logic            snap_valid = 1'b0;
	logic            snap_power;
	logic [7:0]      snap_vol;
	logic [7:0]      snap_pan;
	logic [1:0][3:0] snap_lvl;
	chan_status_t    snap_act;

	assign errors = err_count;

	function automatic string test_name(input logic [2:0] p);
		case (p)
			3'd2:    return "power";
			3'd3:    return "status";
			3'd4:    return "length";
			default: return "readback";
		endcase
	endfunction

	// read value from the register rules
	function automatic logic [7:0] exp_read(input logic [7:0] addr);
		logic [7:0] base;
		logic [7:0] r;
		logic [1:0] idx;
		exp_read = 8'hff; // unmapped
		if (addr == 8'h24)
			exp_read = m_power ? m_vol : 8'h00;
		else if (addr == 8'h25)
			exp_read = m_power ? m_pan : 8'h00;
		else if (addr == 8'h26)
			exp_read = {m_power, 3'b111, 2'b00, m_active};
		for (int c = 0; c < 2; c++) begin
			base = (c == 0) ? 8'h11 : 8'h16;
			if (addr >= base && addr < base + 8'd4) begin
				idx = 2'(addr - base);
				r = m_power ? m_ch[c][idx] : 8'h00;
				case (idx)
					2'd0:    exp_read = {r[7:6], 6'h3f}; // length is write only
					2'd1:    exp_read = r;
					2'd2:    exp_read = 8'hff;
					default: exp_read = 8'hbf | (r & 8'h40);
				endcase
			end
		end
	endfunction

	// one candidate per on/off combination of the two duty outputs
	function automatic int side_value(input int pick, input logic [1:0] en,
		input logic [2:0] vol);
		int sum;
		sum = 0;
		for (int c = 0; c < 2; c++) begin
			if (pick[c] && en[c] && snap_act[c])
				sum += snap_lvl[c];
		end
		return snap_power ? (int'(vol) + 1) * sum : 0;
	endfunction

	task automatic check_side(input string side, input logic [7:0] actual,
		input logic [1:0] en, input logic [2:0] vol);
		int   cand [4];
		logic hit;
		hit = 1'b0;
		for (int p = 0; p < 4; p++) begin
			cand[p] = side_value(p, en, vol);
			if (cand[p] == int'(actual))
				hit = 1'b1;
		end
		if (!hit) begin
			err_count++;
			$display("[FAIL] mixing %s: expected one of %0d %0d %0d %0d, actual %0d",
				side, cand[0], cand[1], cand[2], cand[3], actual);
		end
	endtask

	always @(posedge apuv_4mhz or negedge rst_n) begin
		if (!rst_n) begin
			rd_pend = 1'b0;
			snap_valid = 1'b0;
		end else begin
			if (rd_pend && ((rd_data | rd_ign) !== (rd_exp | rd_ign))) begin
				err_count++;
				$display("[FAIL] %s ff%h: expected %h, actual %h",
					test_name(rd_phase), rd_addr, rd_exp, rd_data);
			end
			rd_pend = bus.rd;
			if (bus.rd) begin
				rd_exp = exp_read(bus.addr);
				rd_ign = (bus.addr == 8'h26) ? {6'b0, status_mask} : 8'h00;
				rd_addr = bus.addr;
				rd_phase = phase;
			end
			// sample is one cycle behind the register state
			if (snap_valid) begin
				check_side("left", sample.left, snap_pan[5:4], snap_vol[6:4]);
				check_side("right", sample.right, snap_pan[1:0], snap_vol[2:0]);
			end
			snap_power = m_power;
			snap_vol = m_vol;
			snap_pan = m_pan;
			snap_act = m_active;
			for (int c = 0; c < 2; c++)
				snap_lvl[c] = m_ch[c][1][7:4];
			snap_valid = 1'b1;
		end
	end

endmodule

// ==== sim/apu_sva.sv ====
module apu_sva (
	input logic       apuv_4mhz,
	input logic       rst_n,
	input logic       en_2mhz,
	input logic       en_1mhz,
	input logic       frame_tick,
	input logic       test_mode,
	input logic       power_on,
	input logic       power_n_reset,
	input logic [7:0] vol_reg,
	input logic [7:0] pan_reg
);
	int fail_count = 0; // failed assertions so far

	a_en2_pulse: assert property (@(posedge apuv_4mhz) disable iff (!rst_n)
		en_2mhz |=> !en_2mhz)
	else begin
		fail_count++;
		$error("en_2mhz high for more than one cycle");
	end

	a_en1_pulse: assert property (@(posedge apuv_4mhz) disable iff (!rst_n)
		en_1mhz |=> !en_1mhz)
	else begin
		fail_count++;
		$error("en_1mhz high for more than one cycle");
	end

	a_off_clear: assert property (@(posedge apuv_4mhz) disable iff (!rst_n)
		!power_on |=> (vol_reg == 8'h00) && (pan_reg == 8'h00))
	else begin
		fail_count++;
		$error("ff24 or ff25 not cleared after power off");
	end

	// fast tick only comes from the 1 MHz divider
	a_test_tick: assert property (@(posedge apuv_4mhz) disable iff (!rst_n)
		(frame_tick && test_mode) |-> en_1mhz)
	else begin
		fail_count++;
		$error("frame tick in test mode without a 1 MHz enable");
	end

	a_power_reset: assert property (@(posedge apuv_4mhz) disable iff (!rst_n)
		!power_on |-> !power_n_reset)
	else begin
		fail_count++;
		$error("power_n_reset high while the power bit is 0");
	end

endmodule

bind apu_control apu_sva u_sva (
	.apuv_4mhz     (apuv_4mhz),
	.rst_n         (rst_n),
	.en_2mhz       (en_2mhz),
	.en_1mhz       (en_1mhz),
	.frame_tick    (frame_tick),
	.test_mode     (test_mode),
	.power_on      (power_on),
	.power_n_reset (power_n_reset),
	.vol_reg       (vol_reg),
	.pan_reg       (pan_reg)
);

// ==== sim/apu_tb.sv ====
module apu_tb
	import apu_bus_pkg::*;
	import apu_audio_pkg::*;
();
	localparam logic [10:0][7:0] MAPPED = {8'h26, 8'h25, 8'h24, 8'h19, 8'h18, 8'h17,
		8'h16, 8'h14, 8'h13, 8'h12, 8'h11}; // index 0 is ff11 and index 10 is ff26

	logic                 apuv_4mhz;
	logic                 rst_n;
	logic                 t1_nt2;
	logic                 byfe_128hz;
	apu_bus_t             bus;
	logic [7:0]           rd_data;
	stereo_sample_t       sample;
	logic                 m_power;
	logic [7:0]           m_vol;
	logic [7:0]           m_pan;
	logic [1:0][3:0][7:0] m_ch; // by channel then register offset
	chan_status_t         m_active;
	logic                 expire_req; // channel 1 length seen to run out
	logic [1:0]           status_mask;
	logic [2:0]           phase;
	int                   check_errors;
	int                   timeouts;

	apu_top UUT (
		.apuv_4mhz  (apuv_4mhz),
		.rst_n      (rst_n),
		.t1_nt2     (t1_nt2),
		.byfe_128hz (byfe_128hz),
		.bus        (bus),
		.rd_data    (rd_data),
		.sample     (sample)
	);

	apu_checker u_checker (
		.apuv_4mhz   (apuv_4mhz),
		.rst_n       (rst_n),
		.bus         (bus),
		.rd_data     (rd_data),
		.sample      (sample),
		.m_power     (m_power),
		.m_vol       (m_vol),
		.m_pan       (m_pan),
		.m_ch        (m_ch),
		.m_active    (m_active),
		.status_mask (status_mask),
		.phase       (phase),
		.errors      (check_errors)
	);

	initial begin
		apuv_4mhz = 1'b0;
		forever #4 apuv_4mhz = ~apuv_4mhz;
	end

	// register model clears on the edge after power goes off
	always @(posedge apuv_4mhz or negedge rst_n) begin : model_update
		logic [7:0] base;
		if (!rst_n) begin
			m_power <= 1'b0;
			m_vol <= '0;
			m_pan <= '0;
			m_ch <= '0;
			m_active <= '0;
		end else begin
			if (!m_power) begin
				m_vol <= '0;
				m_pan <= '0;
				m_ch <= '0;
				m_active <= '0;
			end else if (bus.wr) begin
				if (bus.addr == 8'h24)
					m_vol <= bus.wdata;
				if (bus.addr == 8'h25)
					m_pan <= bus.wdata;
				for (int c = 0; c < 2; c++) begin
					base = (c == 0) ? 8'h11 : 8'h16;
					if (bus.addr >= base && bus.addr < base + 8'd4) begin
						m_ch[c][2'(bus.addr - base)] <= bus.wdata;
						if (bus.addr == base + 8'd3 && bus.wdata[7] && m_ch[c][1][7:4] != 4'd0)
							m_active[c] <= 1'b1; // trigger needs a nonzero volume
					end
				end
			end
			if (bus.wr && bus.addr == 8'h26)
				m_power <= bus.wdata[7];
			if (expire_req)
				m_active[0] <= 1'b0;
		end
	end

	task automatic drive_op(input logic [7:0] addr, input logic [7:0] data,
		input logic wr, input logic rd);
		@(posedge apuv_4mhz);
		bus <= '{addr: addr, wdata: data, wr: wr, rd: rd};
	endtask

	task automatic write_reg(input logic [7:0] addr, input logic [7:0] data);
		drive_op(addr, data, 1'b1, 1'b0);
	endtask

	task automatic read_reg(input logic [7:0] addr);
		drive_op(addr, 8'h00, 1'b0, 1'b1);
	endtask

	task automatic idle_cycle();
		drive_op(8'h00, 8'h00, 1'b0, 1'b0);
	endtask

	task automatic read_all();
		for (int i = 0; i < 11; i++)
			read_reg(MAPPED[i]);
	endtask

	task automatic random_ops(input int n);
		int         sel;
		int         kind;
		logic [7:0] a;
		logic [7:0] d;
		repeat (n) begin
			sel = $urandom_range(0, 15);
			a = (sel < 11) ? MAPPED[sel] : 8'($urandom);
			d = 8'($urandom);
			if (a == 8'h26)
				d[7] = ($urandom_range(0, 7) != 0); // mostly stays powered
			kind = $urandom_range(0, 4);
			if (kind < 2)
				write_reg(a, d);
			else if (kind < 4)
				read_reg(a);
			else
				idle_cycle();
		end
		idle_cycle();
	endtask

	task automatic power_checks();
		repeat (4) begin
			random_ops(80);
			write_reg(8'h26, 8'h00);
			read_all();
			for (int i = 0; i < 10; i++)
				write_reg(MAPPED[i], 8'($urandom)); // all ignored
			read_all();
			write_reg(8'h26, 8'h80);
			read_all();
		end
	endtask

	task automatic status_checks();
		logic [7:0] base;
		write_reg(8'h26, 8'h00);
		write_reg(8'h26, 8'h80);
		for (int c = 0; c < 2; c++) begin
			base = (c == 0) ? 8'h11 : 8'h16;
			write_reg(base + 8'd1, 8'h00);
			write_reg(base + 8'd3, 8'h80); // trigger at volume 0
			read_reg(8'h26);
			write_reg(base + 8'd1, 8'h70);
			write_reg(base + 8'd3, 8'h80);
			read_reg(8'h26);
		end
	endtask

	task automatic length_checks();
		logic [5:0] len;
		logic [7:0] st;
		int         limit;
		int         elapsed;
		len = 6'(56 + $urandom_range(0, 7));
		limit = (64 - len) * 16 * 4 + 200;
		idle_cycle();
		t1_nt2 <= 1'b1;
		write_reg(8'h26, 8'h00);
		write_reg(8'h26, 8'h90); // power on with test mode
		write_reg(8'h11, {2'b10, len});
		write_reg(8'h12, 8'hf0);
		write_reg(8'h16, 8'h3f);
		write_reg(8'h17, 8'hf0);
		write_reg(8'h19, 8'h80); // channel 2 without length enable
		idle_cycle();
		status_mask <= 2'b01;
		write_reg(8'h14, 8'hc0);
		elapsed = 0;
		st = 8'h01;
		while (st[0] && elapsed < limit) begin
			read_reg(8'h26);
			idle_cycle();
			@(posedge apuv_4mhz);
			st = rd_data;
			elapsed += 3;
		end
		if (st[0]) begin
			timeouts++;
			$display("channel 1 status bit still set %0d cycles after the trigger", elapsed);
		end
		expire_req <= 1'b1;
		idle_cycle();
		expire_req <= 1'b0;
		status_mask <= 2'b00;
		repeat (256) idle_cycle(); // several more frame ticks
		read_reg(8'h26);
		write_reg(8'h26, 8'h80); // leave test mode
		idle_cycle();
		t1_nt2 <= 1'b0;
	endtask

	initial begin
		rst_n = 1'b0;
		t1_nt2 = 1'b0;
		byfe_128hz = 1'b0; // no external frame ticks
		bus = '0;
		expire_req = 1'b0;
		status_mask = 2'b00;
		phase = 3'd1;
		timeouts = 0;
		void'($urandom(24785));
		repeat (2) @(posedge apuv_4mhz);
		rst_n <= 1'b1;
		write_reg(8'h26, 8'h80);
		random_ops(600);
		phase <= 3'd2;
		power_checks();
		phase <= 3'd3;
		status_checks();
		phase <= 3'd4;
		length_checks();
		phase <= 3'd1;
		random_ops(300);
		repeat (3) idle_cycle();
		$display("checker errors %0d, assertion failures %0d, timeouts %0d",
			check_errors, UUT.u_control.u_sva.fail_count, timeouts);
		if (check_errors + UUT.u_control.u_sva.fail_count + timeouts == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule
